/* rtl/tx_bit_pkg.sv */
// transmit bit interface types
package tx_bit_pkg;

    // four priority queues, queue 0 served first
    localparam int NUM_QUEUES = 4;

    // start pulse width toward the phy, in cycles
    localparam int START_STRETCH = 6;

    // no new trigger this many cycles after a try-complete
    localparam int COMPLETE_HOLDOFF = 4;

    typedef logic [1:0] queue_idx_t;

    // one bit per queue
    typedef logic [NUM_QUEUES-1:0] queue_mask_t;

    // occupancy, enough for a depth of 64
    typedef logic [6:0] fifo_count_t;

    // descriptor pushed by the host at the end of a dma
    typedef struct packed {
        // linux priority of the frame
        logic [1:0]  prio;
        // sequence number reported back to the mac
        logic [9:0]  sn;
        logic [1:0]  rsvd;
        logic [3:0]  retrans_limit;
        logic        need_ack;
        // frame length in stream words
        logic [12:0] num_words;
    } tx_desc_t;

    // channel state seen by the arbiter
    typedef struct packed {
        // baseband still transmitting
        logic bb_busy;
        // low mac control fsm idle
        logic ctl_idle;
    } chan_status_t;

endpackage

/* rtl/desc_fifo.sv */
`timescale 1ns/100ps
// descriptor fifo with fall-through head
module desc_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wr_en,
    input  tx_bit_pkg::tx_desc_t    din,
    input  logic                    rd_en,
    output tx_bit_pkg::tx_desc_t    dout,
    output logic                    empty,
    output logic                    full,
    output tx_bit_pkg::fifo_count_t count
);
    import tx_bit_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    tx_desc_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // protect pointers against misuse
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({do_wr, do_rd})
                2'b10:   count <= count + 7'd1;
                2'b01:   count <= count - 7'd1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // head always visible
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == fifo_count_t'(FIFO_DEPTH));

    // host must not overrun a queue, fsm must not pop an empty one
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty);

endmodule

/* rtl/desc_queue_bank.sv */
`timescale 1ns/100ps
// four descriptor priority queues
module desc_queue_bank #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    recv_done,
    input  tx_bit_pkg::queue_idx_t  queue_sel,
    input  tx_bit_pkg::tx_desc_t    desc_in,
    input  tx_bit_pkg::queue_mask_t pop,
    output tx_bit_pkg::queue_mask_t queue_empty,
    output tx_bit_pkg::fifo_count_t queue_count [tx_bit_pkg::NUM_QUEUES],
    output tx_bit_pkg::tx_desc_t    head [tx_bit_pkg::NUM_QUEUES]
);
    import tx_bit_pkg::*;

    logic        recv_done_q;
    logic        recv_done_qq;
    logic        dma_done;
    queue_mask_t wr_en;
    tx_desc_t    desc_q;

    // end of dma is a falling recv_done, taken from the registered copy
    assign dma_done = recv_done_qq && !recv_done_q;

    // edge detect and one-hot write enable
    always_ff @(posedge clk) begin
        if (!rstn) begin
            // reset low so a held-low level does not look like a fall
            recv_done_q  <= 1'b0;
            recv_done_qq <= 1'b0;
            wr_en        <= '0;
        end else begin
            recv_done_q  <= recv_done;
            recv_done_qq <= recv_done_q;
            wr_en        <= dma_done ? (queue_mask_t'(1) << queue_sel) : '0;
        end
    end

    // descriptor staged alongside the write enable
    always_ff @(posedge clk) begin
        if (dma_done) begin
            desc_q <= desc_in;
        end
    end

    // one fifo per priority
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        desc_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk   (clk),
            .rstn  (rstn),
            .wr_en (wr_en[q]),
            .din   (desc_q),
            .rd_en (pop[q]),
            .dout  (head[q]),
            .empty (queue_empty[q]),
            .full  (),
            .count (queue_count[q])
        );
    end

    // the fsm serves one queue at a time
    a_pop_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(pop));

endmodule

/* rtl/tx_ctrl_fsm.sv */
`timescale 1ns/100ps
// queue arbitration and frame copy
module tx_ctrl_fsm #(
    parameter int DATA_WIDTH     = 64,
    parameter int BUF_ADDR_WIDTH = 10
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  tx_bit_pkg::queue_mask_t   queue_empty,
    input  tx_bit_pkg::tx_desc_t      head [tx_bit_pkg::NUM_QUEUES],
    input  tx_bit_pkg::queue_mask_t   tx_allowed,
    input  tx_bit_pkg::chan_status_t  chan,
    input  logic                      tx_try_complete,
    input  logic                      tx_end,
    input  logic                      auto_start_mode,
    input  logic [BUF_ADDR_WIDTH-1:0] num_dma_symbol_th,
    input  logic [DATA_WIDTH-1:0]     s_data,
    input  logic                      s_emptyn,
    output tx_bit_pkg::queue_mask_t   pop,
    output logic                      s_ask,
    output logic                      high_trigger,
    output tx_bit_pkg::queue_idx_t    tx_queue_idx,
    output logic                      buf_we,
    output logic [BUF_ADDR_WIDTH-1:0] buf_waddr,
    output logic [DATA_WIDTH-1:0]     buf_wdata,
    output logic                      start,
    output logic                      tx_pkt_need_ack,
    output logic [3:0]                tx_pkt_retrans_limit,
    output logic [9:0]                tx_pkt_sn,
    output logic [1:0]                linux_prio
);
    import tx_bit_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_chance,
        fetch,
        copy
    } state_t;

    localparam int BUF_DEPTH = 2 ** BUF_ADDR_WIDTH;

    state_t                    state;
    tx_desc_t                  cur_desc;
    logic [12:0]               words_left;
    logic [BUF_ADDR_WIDTH-1:0] wr_cnt;
    logic                      take;
    logic [COMPLETE_HOLDOFF-2:0] cmpl_sr;
    logic                      holdoff;
    logic                      can_arb;
    queue_idx_t                pick_idx;
    logic [START_STRETCH-1:0]  start_sr;
    logic                      th_hit;

    // stream handshake, one word per edge
    assign take = s_ask && s_emptyn;

    // current pulse plus the last few cycles
    assign holdoff = tx_try_complete || (|cmpl_sr);

    // channel free and something queued
    assign can_arb = !chan.bb_busy && chan.ctl_idle && !holdoff && !(&queue_empty);

    // lowest numbered non-empty queue wins
    always_comb begin
        pick_idx = '0;
        for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
            if (!queue_empty[q]) begin
                pick_idx = queue_idx_t'(q);
            end
        end
    end

    // control fsm
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= idle;
            tx_queue_idx <= '0;
            high_trigger <= 1'b0;
            pop          <= '0;
            s_ask        <= 1'b0;
            buf_we       <= 1'b0;
            wr_cnt       <= '0;
            words_left   <= '0;
        end else begin
            high_trigger <= 1'b0;
            pop          <= '0;
            // write lands one cycle after the take
            buf_we       <= take;

            if (take) begin
                wr_cnt     <= wr_cnt + 1'b1;
                words_left <= words_left - 13'd1;
                // stop asking on the last word
                if (words_left == 13'd1) begin
                    s_ask <= 1'b0;
                end
            end

            case (state)
                idle: begin
                    if (can_arb) begin
                        tx_queue_idx <= pick_idx;
                        high_trigger <= 1'b1;
                        state        <= wait_chance;
                    end
                end
                wait_chance: begin
                    // low mac grants the chosen queue
                    if (tx_allowed[tx_queue_idx]) begin
                        pop   <= queue_mask_t'(1) << tx_queue_idx;
                        state <= fetch;
                    end
                end
                fetch: begin
                    // head still valid on the pop edge
                    words_left <= head[tx_queue_idx].num_words;
                    wr_cnt     <= '0;
                    s_ask      <= 1'b1;
                    state      <= copy;
                end
                copy: begin
                    // busy until the phy is done with the frame
                    if (tx_end) begin
                        s_ask <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // write data path
    always_ff @(posedge clk) begin
        buf_waddr <= wr_cnt;
        buf_wdata <= s_data;
    end

    // descriptor of the frame in flight
    always_ff @(posedge clk) begin
        if (state == fetch) begin
            cur_desc <= head[tx_queue_idx];
        end
    end

    // threshold word written, phy may start
    assign th_hit = buf_we && (buf_waddr == num_dma_symbol_th) && (num_dma_symbol_th != '0);

    // holdoff, start stretch and completion report
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmpl_sr    <= '0;
            start_sr   <= '0;
            tx_pkt_sn  <= '0;
            linux_prio <= '0;
        end else begin
            cmpl_sr  <= {cmpl_sr[COMPLETE_HOLDOFF-3:0], tx_try_complete};
            start_sr <= {start_sr[START_STRETCH-2:0], th_hit};
            if (tx_try_complete) begin
                tx_pkt_sn  <= cur_desc.sn;
                linux_prio <= cur_desc.prio;
            end
        end
    end

    // manual mode keeps start low
    assign start = auto_start_mode && (|start_sr);

    assign tx_pkt_need_ack      = cur_desc.need_ack;
    assign tx_pkt_retrans_limit = cur_desc.retrans_limit;

    // a queued frame must fit the packet buffer
    a_desc_len: assert property (@(posedge clk) disable iff (!rstn)
        (state == fetch) |-> (head[tx_queue_idx].num_words != '0 &&
                              head[tx_queue_idx].num_words <= BUF_DEPTH));

endmodule

/* rtl/tx_pkt_ram.sv */
`timescale 1ns/100ps
// transmit packet buffer
module tx_pkt_ram #(
    parameter int DATA_WIDTH     = 64,
    parameter int BUF_ADDR_WIDTH = 10
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [BUF_ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0]     wdata,
    input  logic [BUF_ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0]     rdata
);

    localparam int DEPTH = 2 ** BUF_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // write port, fed by the copy
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // phy read port, one cycle latency
    always_ff @(posedge clk) begin
        // same-address collision returns the new word
        if (we && (waddr == raddr)) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* rtl/tx_bit_intf.sv */
`timescale 1ns/100ps
// transmit bit interface top
module tx_bit_intf #(
    parameter int DATA_WIDTH     = 64,
    parameter int BUF_ADDR_WIDTH = 10,
    parameter int FIFO_DEPTH     = 64
) (
    input  logic                      clk,
    input  logic                      rstn,
    // descriptor push from the host
    input  logic                      recv_done,
    input  tx_bit_pkg::queue_idx_t    queue_sel,
    input  tx_bit_pkg::tx_desc_t      desc_in,
    output tx_bit_pkg::fifo_count_t   queue_count [tx_bit_pkg::NUM_QUEUES],
    // low mac side
    input  tx_bit_pkg::queue_mask_t   tx_allowed,
    input  tx_bit_pkg::chan_status_t  chan,
    input  logic                      tx_try_complete,
    output logic                      high_trigger,
    output tx_bit_pkg::queue_idx_t    tx_queue_idx,
    output logic                      tx_pkt_need_ack,
    output logic [3:0]                tx_pkt_retrans_limit,
    output logic [9:0]                tx_pkt_sn,
    output logic [1:0]                linux_prio,
    // start control
    input  logic                      auto_start_mode,
    input  logic [BUF_ADDR_WIDTH-1:0] num_dma_symbol_th,
    output logic                      start,
    // dma stream
    input  logic [DATA_WIDTH-1:0]     s_data,
    input  logic                      s_emptyn,
    output logic                      s_ask,
    // phy side
    input  logic                      tx_end,
    input  logic [BUF_ADDR_WIDTH-1:0] phy_raddr,
    output logic [DATA_WIDTH-1:0]     phy_rdata
);
    import tx_bit_pkg::*;

    queue_mask_t               queue_empty;
    queue_mask_t               pop;
    tx_desc_t                  head [NUM_QUEUES];
    logic                      buf_we;
    logic [BUF_ADDR_WIDTH-1:0] buf_waddr;
    logic [DATA_WIDTH-1:0]     buf_wdata;

    desc_queue_bank #(.FIFO_DEPTH(FIFO_DEPTH)) u_queues (
        .clk(clk), .rstn(rstn), .recv_done(recv_done), .queue_sel(queue_sel),
        .desc_in(desc_in), .pop(pop), .queue_empty(queue_empty),
        .queue_count(queue_count), .head(head)
    );

    tx_ctrl_fsm #(.DATA_WIDTH(DATA_WIDTH), .BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) u_ctrl (
        .clk(clk), .rstn(rstn), .queue_empty(queue_empty), .head(head),
        .tx_allowed(tx_allowed), .chan(chan), .tx_try_complete(tx_try_complete),
        .tx_end(tx_end), .auto_start_mode(auto_start_mode),
        .num_dma_symbol_th(num_dma_symbol_th), .s_data(s_data), .s_emptyn(s_emptyn),
        .pop(pop), .s_ask(s_ask), .high_trigger(high_trigger), .tx_queue_idx(tx_queue_idx),
        .buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata), .start(start),
        .tx_pkt_need_ack(tx_pkt_need_ack), .tx_pkt_retrans_limit(tx_pkt_retrans_limit),
        .tx_pkt_sn(tx_pkt_sn), .linux_prio(linux_prio)
    );

    // port b only reads, for the phy
    tx_pkt_ram #(.DATA_WIDTH(DATA_WIDTH), .BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) u_buf (
        .clk(clk), .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
        .raddr(phy_raddr), .rdata(phy_rdata)
    );

endmodule

/* include/tx_bit_checks.svh */
// transmit bit interface compare tasks
`ifndef TX_BIT_CHECKS_SVH
`define TX_BIT_CHECKS_SVH

// completion report against the granted descriptor
task automatic check_report(input tx_bit_pkg::tx_desc_t exp, input logic [9:0] sn,
                            input logic [1:0] prio, input logic need_ack,
                            input logic [3:0] retrans_limit);
    if (sn !== exp.sn || prio !== exp.prio || need_ack !== exp.need_ack ||
        retrans_limit !== exp.retrans_limit) begin
        $display("mismatch at %0d ns: report sn %0d/%0d prio %0d/%0d", $time,
                 sn, exp.sn, prio, exp.prio);
        $display("  ack %0b/%0b limit %0d/%0d", need_ack, exp.need_ack,
                 retrans_limit, exp.retrans_limit);
        abort_run();
    end
endtask

// queue occupancy
task automatic check_count(input string what, input tx_bit_pkg::fifo_count_t got,
                           input tx_bit_pkg::fifo_count_t exp);
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

// single-bit control output
task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
        abort_run();
    end
endtask

// queue chosen by the arbiter
task automatic check_queue(input string what, input tx_bit_pkg::queue_idx_t got,
                           input tx_bit_pkg::queue_idx_t exp);
    if (got !== exp) begin
        $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

// one packet buffer word read back by the phy port
task automatic check_word(input int addr, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0d ns: buffer[%0d] got %h expected %h", $time, addr, got, exp);
        abort_run();
    end
endtask

// measured high time of a pulse, in cycles
task automatic check_pulse(input string what, input int width, input int exp);
    if (width != exp) begin
        $display("mismatch at %0d ns: %s pulse width %0d expected %0d", $time, what,
                 width, exp);
        abort_run();
    end
endtask

// event tally kept by the testbench, such as words taken
task automatic check_tally(input string what, input int got, input int exp);
    if (got != exp) begin
        $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

/* tb/tx_bit_tb.sv */
`timescale 1ns/100ps
// transmit bit interface testbench
module tx_bit_tb;
    import tx_bit_pkg::*;

    // start pulse width toward the phy, in cycles
    localparam int START_WIDTH = 6;

    logic                clk;
    logic                rstn;
    logic                recv_done;
    queue_idx_t          queue_sel;
    tx_desc_t            desc_in;
    fifo_count_t         queue_count [NUM_QUEUES];
    queue_mask_t         tx_allowed;
    chan_status_t        chan;
    logic                tx_try_complete;
    logic                high_trigger;
    queue_idx_t          tx_queue_idx;
    logic                tx_pkt_need_ack;
    logic [3:0]          tx_pkt_retrans_limit;
    logic [9:0]          tx_pkt_sn;
    logic [1:0]          linux_prio;
    logic                auto_start_mode;
    logic [9:0]          num_dma_symbol_th;
    logic                start;
    logic [63:0]         s_data;
    logic                s_emptyn;
    logic                s_ask;
    logic                tx_end;
    logic [9:0]          phy_raddr;
    logic [63:0]         phy_rdata;

    integer      seed = 32'h1e58_3c38;
    int          n_records = 0;
    // reference queues, frame in flight and stream capture
    tx_desc_t    model_q [NUM_QUEUES][$];
    tx_desc_t    cur;
    logic [63:0] got_words [$];
    queue_idx_t  trig_q [$];
    int          take_cnt = 0;
    bit          streaming = 0;
    int          start_hi = 0;
    int          start_rises = 0;
    logic        start_prev = 1'b0;

    // fail message and stop
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    `include "tx_bit_checks.svh"

    tx_bit_intf #(.DATA_WIDTH(64), .BUF_ADDR_WIDTH(10), .FIFO_DEPTH(64)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // stream source, holds a word until it is taken
    always @(posedge clk) begin
        if (streaming) begin
            if (s_ask && s_emptyn) begin
                got_words.push_back(s_data);
                take_cnt++;
            end
            if (!s_emptyn || s_ask) begin
                s_emptyn <= (($random(seed) & 3) != 0);
                s_data   <= {$random(seed), $random(seed)};
            end
        end else begin
            s_emptyn <= 1'b0;
        end
    end

    // trigger and start monitors
    always @(negedge clk) begin
        if (high_trigger) begin
            trig_q.push_back(tx_queue_idx);
        end
        if (start) begin
            start_hi++;
        end
        if (start && !start_prev) begin
            start_rises++;
        end
        start_prev = start;
    end

    initial begin
        wait (n_records > 0);
        repeat (n_records * 400) @(posedge clk);
        $display("timeout, the DUT stopped responding");
        abort_run();
    end

    task automatic push_desc(input int q, input tx_desc_t d);
        @(posedge clk);
        desc_in   <= d;
        queue_sel <= queue_idx_t'(q);
        recv_done <= 1'b1;
        @(posedge clk);
        recv_done <= 1'b0;
        // count must still be old one edge early
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        check_count("queue count one edge early", queue_count[q],
                    fifo_count_t'(model_q[q].size()));
        model_q[q].push_back(d);
        @(negedge clk);
        for (int i = 0; i < NUM_QUEUES; i++) begin
            check_count($sformatf("queue %0d count", i), queue_count[i],
                        fifo_count_t'(model_q[i].size()));
        end
    endtask

    task automatic run_frame(input int delay);
        int   exp_q;
        int   n;
        logic exp_start;
        exp_q = -1;
        for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
            if (model_q[i].size() > 0) begin
                exp_q = i;
            end
        end
        if (exp_q < 0) begin
            $display("test file grants a frame while every queue is empty");
            abort_run();
        end
        cur = model_q[exp_q].pop_front();
        n   = int'(cur.num_words);
        @(negedge clk);
        // start only if the threshold word is part of the frame
        exp_start = auto_start_mode && num_dma_symbol_th != 0 && int'(num_dma_symbol_th) < n;
        take_cnt = 0;
        got_words.delete();
        streaming = 1;
        @(posedge clk);
        start_hi    = 0;
        start_rises = 0;
        chan <= '{bb_busy: 1'b0, ctl_idle: 1'b1};
        while (trig_q.size() == 0) begin
            @(negedge clk);
        end
        check_queue("trigger queue", trig_q.pop_front(), queue_idx_t'(exp_q));
        @(posedge clk);
        chan <= '{bb_busy: 1'b1, ctl_idle: 1'b1};
        repeat (delay) @(posedge clk);
        tx_allowed <= queue_mask_t'(1) << exp_q;
        @(posedge clk);
        tx_allowed <= '0;
        while (take_cnt < n) begin
            @(negedge clk);
        end
        // let the start stretch run out
        repeat (12) @(negedge clk);
        check_tally("words taken", take_cnt, n);
        check_level("s_ask after copy", s_ask, 1'b0);
        check_tally("start rises", start_rises, exp_start ? 1 : 0);
        check_pulse("start", start_hi, exp_start ? START_WIDTH : 0);
        check_tally("extra triggers", trig_q.size(), 0);
        streaming = 0;
    endtask

    task automatic read_back();
        for (int a = 0; a < got_words.size(); a++) begin
            @(posedge clk);
            phy_raddr <= 10'(a);
            @(posedge clk);
            @(negedge clk);
            check_word(a, phy_rdata, got_words[a]);
        end
    endtask

    task automatic complete_frame();
        @(posedge clk);
        tx_try_complete <= 1'b1;
        @(posedge clk);
        tx_try_complete <= 1'b0;
        @(negedge clk);
        check_report(cur, tx_pkt_sn, linux_prio, tx_pkt_need_ack, tx_pkt_retrans_limit);
        @(posedge clk);
        tx_end <= 1'b1;
        @(posedge clk);
        tx_end <= 1'b0;
    endtask

    initial begin
        string    recs [$];
        string    line;
        int       fd;
        int       f [6];
        byte      op;
        tx_desc_t d;
        rstn = 1'b0;
        recv_done = 1'b0;
        queue_sel = '0;
        desc_in = '0;
        tx_allowed = '0;
        chan = '{bb_busy: 1'b1, ctl_idle: 1'b1};
        tx_try_complete = 1'b0;
        auto_start_mode = 1'b0;
        num_dma_symbol_th = '0;
        s_data = '0;
        s_emptyn = 1'b0;
        tx_end = 1'b0;
        phy_raddr = '0;
        fd = $fopen("tb/tx_bit_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file tb/tx_bit_tests.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                recs.push_back(line);
            end
        end
        $fclose(fd);
        n_records = recs.size();
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_level("s_ask after reset", s_ask, 1'b0);
        check_level("start after reset", start, 1'b0);
        check_level("high_trigger after reset", high_trigger, 1'b0);
        for (int i = 0; i < NUM_QUEUES; i++) begin
            check_count($sformatf("queue %0d reset count", i), queue_count[i], '0);
        end
        foreach (recs[r]) begin
            op = recs[r].getc(0);
            f  = '{default: 0};
            void'($sscanf(recs[r].substr(1, recs[r].len() - 1), "%h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5]));
            case (op)
                "D": begin
                    d = '{prio: 2'(f[1]), sn: 10'(f[2]), rsvd: 2'b0,
                          retrans_limit: 4'(f[3]), need_ack: f[4][0],
                          num_words: 13'(f[5])};
                    push_desc(f[0], d);
                end
                "S": begin
                    @(posedge clk);
                    auto_start_mode   <= f[0][0];
                    num_dma_symbol_th <= 10'(f[1]);
                end
                "G": run_frame(f[0]);
                "K": read_back();
                "C": complete_frame();
                default: begin
                    $display("unknown opcode in test record %0d", r);
                    abort_run();
                end
            endcase
        end
        repeat (20) @(negedge clk);
        check_tally("triggers left over", trig_q.size(), 0);
        $display("Regression passed");
        $finish;
    end

endmodule

/* tb/tx_bit_tests.txt */
# opcode and hex fields: D queue prio sn retrans_limit need_ack num_words
# S auto_start_mode threshold, G grant_delay, K buffer check, C complete
S 1 4
D 2 1 0a3 7 1 10
D 0 3 1ff 4 0 8
G 3
K
C
G 1
K
C
S 0 4
D 1 2 050 2 1 c
G 0
K
C
S 1 0
D 3 0 3ff f 0 20
G 2
K
C
S 1 1f
D 0 1 123 1 1 30
D 2 2 2aa 3 0 5
G 5
K
C
G 0
K
C

/* tb.f */
+incdir+include
rtl/tx_bit_pkg.sv
rtl/desc_fifo.sv
rtl/desc_queue_bank.sv
rtl/tx_ctrl_fsm.sv
rtl/tx_pkt_ram.sv
rtl/tx_bit_intf.sv
tb/tx_bit_tb.sv

/* Makefile */
TOP = tx_bit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
